//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - src/rv_pkg.sv
      - src/rv_pipe_if.sv
      - src/rv_bypass_if.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_decode.sv
      - src/rv_execute.sv
      - src/rv_result.sv
      - src/rv_core_top.sv
  - target: test
    files:
      - sim/tb_clkgen.sv
      - sim/tb_rv_core.sv

//--- sim.f
src/rv_pkg.sv
src/rv_pipe_if.sv
src/rv_bypass_if.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
sim/tb_clkgen.sv
sim/tb_rv_core.sv

//--- sim/rv_core_testdata.txt
// @00: one instruction word per line, comment gives pc and assembly
// @40: count of expected write-backs, then one "rd value" pair per line
@00
00500093  // 00 addi x1, x0, 5
FFD00113  // 04 addi x2, x0, -3
002081B3  // 08 add  x3, x1, x2    stall on x2
40208233  // 0c sub  x4, x1, x2
003092B3  // 10 sll  x5, x1, x3
40115313  // 14 srai x6, x2, 1
003153B3  // 18 srl  x7, x2, x3
00112433  // 1c slt  x8, x2, x1
001134B3  // 20 sltu x9, x2, x1
0F00C513  // 24 xori x10, x1, 0xf0
004565B3  // 28 or   x11, x10, x4
00C5F613  // 2c andi x12, x11, 0xc
123456B7  // 30 lui  x13, 0x12345
00001717  // 34 auipc x14, 0x1
00708013  // 38 addi x0, x1, 7
00100793  // 3c addi x15, x0, 1
00208463  // 40 beq  x1, x2, +8    not taken
00108463  // 44 beq  x1, x1, +8    taken
00100F93  // 48 addi x31, x0, 1    skipped
00109463  // 4c bne  x1, x1, +8
00209463  // 50 bne  x1, x2, +8
00200F93  // 54 addi x31, x0, 2
0020C463  // 58 blt  x1, x2, +8
00114463  // 5c blt  x2, x1, +8
00300F93  // 60 addi x31, x0, 3
00115463  // 64 bge  x2, x1, +8
0020D463  // 68 bge  x1, x2, +8
00400F93  // 6c addi x31, x0, 4
00116463  // 70 bltu x2, x1, +8
0020E463  // 74 bltu x1, x2, +8
00500F93  // 78 addi x31, x0, 5
0020F463  // 7c bgeu x1, x2, +8
00117463  // 80 bgeu x2, x1, +8
00600F93  // 84 addi x31, x0, 6
0080086F  // 88 jal  x16, +8
00700F93  // 8c addi x31, x0, 7
09D00893  // 90 addi x17, x0, 0x9d
00088967  // 94 jalr x18, 0(x17)   lands on 0x9c
00800F93  // 98 addi x31, x0, 8
010909B3  // 9c add  x19, x18, x16
0000006F  // a0 jal  x0, 0
@40
00000013
01 00000005
02 FFFFFFFD
03 00000002
04 00000008
05 00000014
06 FFFFFFFE
07 3FFFFFFF
08 00000001
09 00000000
0A 000000F5
0B 000000FD
0C 0000000C
0D 12345000
0E 00001034
0F 00000001
10 0000008C  // jal link
11 0000009D
12 00000098  // jalr link
13 00000124

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam real HALF_NS    = 4.0;   // 8 ns period
    localparam int  RST_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    // released on a falling edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          MEM_WORDS   = 128;
    localparam int          PROG_WORDS  = 64;             // program region of the data file
    localparam int          CNT_ADDR    = 64;             // expected count, pairs follow it
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;  // addi x0, x0, 0
    localparam int          RST_TIMEOUT = 20;
    localparam int          WB_TIMEOUT  = 100;            // cycles allowed per write-back
    localparam int          TAIL_CYCLES = 40;             // quiet window at the end

    logic        clk;
    logic        rst_n;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] mem [0:MEM_WORDS-1];   // program, then expected write-backs
    int          errors = 0;
    int          checked = 0;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_addr_o (fetch_addr),
        .fetch_data_i (fetch_data),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    // ------------------------------------------------------------
    // instruction memory
    // ------------------------------------------------------------
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = addr >> 2;                 // word index
        if (idx >= PROG_WORDS) begin
            return NOP_WORD;             // past the program region
        end
        if ($isunknown(mem[idx])) begin
            return NOP_WORD;             // not loaded from file
        end
        return mem[idx];
    endfunction

    always @(negedge clk) begin
        fetch_data <= fetch_word(fetch_addr);
    end

    // jalr target bit 0 must never reach the pc
    always @(negedge clk) begin
        if (rst_n === 1'b1 && fetch_addr[1:0] !== 2'b00) begin
            $display("** Error: fetch_addr_o = 0x%08h, expected low bits 0x0", fetch_addr);
            errors++;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic wait_reset_release(output logic stuck);
        int cycles;
        cycles = 0;
        stuck  = 1'b0;
        while (rst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (rst_n === 1'b0 && wb_valid !== 1'b0) begin
                $display("** Error: wb_valid_o = 0x%h in reset, expected 0x0", wb_valid);
                errors++;
            end
            if (rst_n === 1'b0 && fetch_addr !== 32'h0) begin
                $display("** Error: fetch_addr_o = 0x%08h in reset, expected 0x00000000",
                         fetch_addr);
                errors++;
            end
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
            stuck = 1'b1;
        end
    endtask

    // always consumes at least one edge, one write-back per call
    task automatic next_wb(output logic found);
        int cycles;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < WB_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (wb_valid === 1'b1) begin
                found = 1'b1;
            end
        end
    endtask

    task automatic compare_wb(input int n, input logic [4:0] exp_rd, input logic [31:0] exp_data);
        if (wb_rd !== exp_rd) begin
            $display("** Error: wb_rd_o = 0x%02h, expected 0x%02h at write-back %0d",
                     wb_rd, exp_rd, n);
            errors++;
        end
        if (wb_data !== exp_data) begin
            $display("** Error: wb_data_o = 0x%08h, expected 0x%08h at write-back %0d",
                     wb_data, exp_data, n);
            errors++;
        end
    endtask

    // program parks in jal x0, 0, nothing more may show up
    task automatic watch_quiet();
        for (int c = 0; c < TAIL_CYCLES; c++) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                $display("** Error: wb_valid_o = 0x%h after the last write-back, expected 0x0",
                         wb_valid);
                errors++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        logic        found;
        logic        stop;
        logic        stuck;
        logic [31:0] exp_count;
        int          base;
        fetch_data = NOP_WORD;
        stop       = 1'b0;
        $readmemh("sim/rv_core_testdata.txt", mem);
        exp_count = mem[CNT_ADDR];
        if ($isunknown(exp_count) || exp_count == 0) begin
            $display("testdata file gave no expected write-backs");
            errors++;
            stop = 1'b1;
        end
        wait_reset_release(stuck);
        stop = stop || stuck;
        for (int i = 0; !stop && i < exp_count; i++) begin
            base = CNT_ADDR + 1 + 2 * i;         // rd word, then data word
            next_wb(found);
            if (!found) begin
                $display("write-back %0d never came within %0d cycles", i, WB_TIMEOUT);
                errors++;
                stop = 1'b1;
            end else begin
                compare_wb(i, mem[base][4:0], mem[base+1]);
                checked++;
            end
        end
        if (!stop) begin
            watch_quiet();
        end
        $display("%0d write-backs checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_e         op_i,
    input  logic [rv_pkg::XLEN-1:0] a_i,
    input  logic [rv_pkg::XLEN-1:0] b_i,
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    carry_o,   // no borrow, a >= b unsigned
    output logic                    zero_o,
    output logic                    neg_o,
    output logic                    ovf_o
);

    logic [rv_pkg::XLEN:0] diff;    // a - b, carry on top
    logic [4:0]            shamt;

    assign diff  = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;
    assign shamt = b_i[4:0];

    // flags from the subtract path
    assign carry_o = diff[rv_pkg::XLEN];
    assign zero_o  = (diff[rv_pkg::XLEN-1:0] == '0);
    assign neg_o   = diff[rv_pkg::XLEN-1];
    assign ovf_o   = (a_i[rv_pkg::XLEN-1] ^ b_i[rv_pkg::XLEN-1]) &&
                     (diff[rv_pkg::XLEN-1] ^ a_i[rv_pkg::XLEN-1]);

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = diff[rv_pkg::XLEN-1:0];
            rv_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_pkg::ALU_SLT:  result_o = {{(rv_pkg::XLEN-1){1'b0}}, neg_o ^ ovf_o};
            rv_pkg::ALU_SLTU: result_o = {{(rv_pkg::XLEN-1){1'b0}}, !carry_o};
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;   // sign fill
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_pkg::ALU_AND:  result_o = a_i & b_i;
            default:          result_o = '0;
        endcase
    end

endmodule

//--- src/rv_bypass_if.sv
`timescale 1ns/1ps

// destinations still in flight, seen by decode
interface rv_bypass_if;

    logic                          ex_wr;     // execute register will write
    logic [rv_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                          res_wr;    // result register writes this cycle
    logic [rv_pkg::REG_ADDR_W-1:0] res_rd;
    logic [rv_pkg::XLEN-1:0]       res_data;

    modport decode (
        input ex_wr, ex_rd, res_wr, res_rd, res_data
    );

    modport execute (output ex_wr, ex_rd);

    modport result (output res_wr, res_rd, res_data);

endinterface

//--- src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [rv_pkg::XLEN-1:0]       fetch_addr_o,
    input  logic [31:0]                   fetch_data_i,
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    logic                          redirect;
    logic [rv_pkg::XLEN-1:0]       redirect_pc;
    logic                          rf_wr;       // result -> regfile in decode
    logic [rv_pkg::REG_ADDR_W-1:0] rf_rd;
    logic [rv_pkg::XLEN-1:0]       rf_data;

    rv_pipe_if #(.payload_t(rv_pkg::dec_payload_t)) u_dec_exe_if ();
    rv_pipe_if #(.payload_t(rv_pkg::exe_payload_t)) u_exe_res_if ();
    rv_bypass_if u_bypass_if ();

    rv_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_data_i  (fetch_data_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .rf_wr_i       (rf_wr),
        .rf_rd_i       (rf_rd),
        .rf_data_i     (rf_data),
        .bypass        (u_bypass_if.decode),
        .to_exe        (u_dec_exe_if.producer)
    );

    rv_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .from_dec (u_dec_exe_if.consumer),
        .to_res   (u_exe_res_if.producer),
        .bypass   (u_bypass_if.execute)
    );

    rv_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .from_exe      (u_exe_res_if.consumer),
        .bypass        (u_bypass_if.result),
        .rf_wr_o       (rf_wr),
        .rf_rd_o       (rf_rd),
        .rf_data_o     (rf_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

//--- src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [rv_pkg::XLEN-1:0]       fetch_addr_o,
    input  logic [31:0]                   fetch_data_i,
    input  logic                          redirect_i,
    input  logic [rv_pkg::XLEN-1:0]       redirect_pc_i,
    input  logic                          rf_wr_i,      // write port, from result
    input  logic [rv_pkg::REG_ADDR_W-1:0] rf_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       rf_data_i,
    rv_bypass_if.decode                   bypass,
    rv_pipe_if.producer                   to_exe
);

    logic                          fd_valid_q;
    logic [rv_pkg::XLEN-1:0]       fd_pc_q;
    logic [31:0]                   fd_instr_q;
    logic                          advance;     // fetch/decode moves on
    logic                          stall;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic                          use_rs1;
    logic                          use_rs2;
    logic                          legal;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    rv_pkg::dec_payload_t          dec_d;

    // ---------------------------------------------------------
    // fetch pc and fetch/decode register
    // ---------------------------------------------------------
    assign advance = !stall && !to_exe.hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_addr_o <= rv_pkg::RESET_PC;
        end else if (redirect_i) begin
            fetch_addr_o <= redirect_pc_i;    // taken branch/jump in result
        end else if (advance) begin
            fetch_addr_o <= fetch_addr_o + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fd_valid_q <= 1'b0;
        end else if (to_exe.kill) begin
            fd_valid_q <= 1'b0;               // wrong-path word dropped
        end else if (advance) begin
            fd_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fd_pc_q    <= fetch_addr_o;
            fd_instr_q <= fetch_data_i;
        end
    end

    // ---------------------------------------------------------
    // opcode decode
    // ---------------------------------------------------------
    assign rs1 = fd_instr_q[19:15];
    assign rs2 = fd_instr_q[24:20];

    always_comb begin
        dec_d        = '0;
        legal        = 1'b0;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        dec_d.opcode = rv_pkg::OPC_OP_IMM;   // unknown words end up as a silent op-imm
        dec_d.alu_op = rv_pkg::ALU_ADD;
        if (fd_instr_q[1:0] == 2'b11) begin
            case (fd_instr_q[6:2])
                rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                    legal   = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = fd_instr_q[5];   // register form only
                    case (fd_instr_q[14:12])
                        3'b000: dec_d.alu_op = (fd_instr_q[5] && fd_instr_q[30]) ?
                                               rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        3'b001: dec_d.alu_op = rv_pkg::ALU_SLL;
                        3'b010: dec_d.alu_op = rv_pkg::ALU_SLT;
                        3'b011: dec_d.alu_op = rv_pkg::ALU_SLTU;
                        3'b100: dec_d.alu_op = rv_pkg::ALU_XOR;
                        3'b101: dec_d.alu_op = fd_instr_q[30] ?
                                               rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        3'b110: dec_d.alu_op = rv_pkg::ALU_OR;
                        default: dec_d.alu_op = rv_pkg::ALU_AND;
                    endcase
                end
                rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL: begin
                    legal = 1'b1;                  // no sources
                end
                rv_pkg::OPC_JALR: begin
                    legal   = 1'b1;
                    use_rs1 = 1'b1;
                end
                rv_pkg::OPC_BRANCH: begin
                    legal        = 1'b1;
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    dec_d.alu_op = rv_pkg::ALU_SUB;   // compare via flags
                end
                default: legal = 1'b0;
            endcase
        end
        if (legal) begin
            dec_d.opcode = rv_pkg::opcode_e'(fd_instr_q[6:2]);
        end
        dec_d.pc    = fd_pc_q;
        dec_d.instr = fd_instr_q;
        dec_d.rd    = fd_instr_q[11:7];
        dec_d.rf_wr = legal && dec_d.opcode != rv_pkg::OPC_BRANCH;
        // result stage is being written this cycle, take its value
        dec_d.op_a  = rs1_data;
        dec_d.op_b  = rs2_data;
        if (bypass.res_wr && bypass.res_rd != '0 && bypass.res_rd == rs1) begin
            dec_d.op_a = bypass.res_data;
        end
        if (bypass.res_wr && bypass.res_rd != '0 && bypass.res_rd == rs2) begin
            dec_d.op_b = bypass.res_data;
        end
    end

    // ---------------------------------------------------------
    // hazard, producer still in execute
    // ---------------------------------------------------------
    assign stall = fd_valid_q && bypass.ex_wr && bypass.ex_rd != '0 &&
                   ((use_rs1 && bypass.ex_rd == rs1) || (use_rs2 && bypass.ex_rd == rs2));

    assign to_exe.valid   = fd_valid_q && !stall;   // bubble while stalled
    assign to_exe.payload = dec_d;

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rf_rd_i),
        .wr_i       (rf_wr_i),
        .wr_data_i  (rf_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

//--- src/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic         clk,
    input  logic         rst_n,
    rv_pipe_if.consumer  from_dec,
    rv_pipe_if.producer  to_res,
    rv_bypass_if.execute bypass
);

    logic                    ex_valid_q;
    rv_pkg::dec_payload_t    ex_q;
    logic [31:0]             ins;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] tgt_sum;
    logic                    carry;
    logic                    zero;
    logic                    neg;
    logic                    ovf;
    logic                    taken;

    // back-pressure and flush go on up to decode
    assign from_dec.hold = to_res.hold;
    assign from_dec.kill = to_res.kill;

    // ---------------------------------------------------------
    // execute register
    // ---------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_q <= 1'b0;
        end else if (to_res.kill) begin
            ex_valid_q <= 1'b0;
        end else if (!to_res.hold) begin
            ex_valid_q <= from_dec.valid;   // stall bubble lands here
        end
    end

    always_ff @(posedge clk) begin
        if (!to_res.hold) begin
            ex_q <= from_dec.payload;
        end
    end

    assign ins = ex_q.instr;

    // immediate by format
    always_comb begin
        case (ex_q.opcode)
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: imm = {ins[31:12], 12'b0};
            rv_pkg::OPC_BRANCH: imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            rv_pkg::OPC_JAL: imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: imm = {{20{ins[31]}}, ins[31:20]};   // I-form
        endcase
    end

    assign alu_b = (ex_q.opcode == rv_pkg::OPC_OP_IMM) ? imm : ex_q.op_b;

    rv_alu u_alu (
        .op_i     (ex_q.alu_op),
        .a_i      (ex_q.op_a),
        .b_i      (alu_b),
        .result_o (alu_res),
        .carry_o  (carry),
        .zero_o   (zero),
        .neg_o    (neg),
        .ovf_o    (ovf)
    );

    // ---------------------------------------------------------
    // branch decision and target
    // ---------------------------------------------------------
    always_comb begin
        case (ex_q.opcode)
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: taken = 1'b1;
            rv_pkg::OPC_BRANCH: begin
                case (ins[14:12])
                    3'b000:  taken = zero;            // beq
                    3'b001:  taken = !zero;           // bne
                    3'b100:  taken = neg ^ ovf;       // blt
                    3'b101:  taken = !(neg ^ ovf);    // bge
                    3'b110:  taken = !carry;          // bltu
                    3'b111:  taken = carry;           // bgeu
                    default: taken = 1'b0;
                endcase
            end
            default: taken = 1'b0;
        endcase
    end

    // jalr is register relative, the rest pc relative
    assign tgt_sum = ((ex_q.opcode == rv_pkg::OPC_JALR) ? ex_q.op_a : ex_q.pc) + imm;

    assign to_res.valid           = ex_valid_q;
    assign to_res.payload.pc      = ex_q.pc;
    assign to_res.payload.opcode  = ex_q.opcode;
    assign to_res.payload.alu_res = alu_res;
    assign to_res.payload.imm     = imm;
    assign to_res.payload.taken   = taken;
    assign to_res.payload.target  = {tgt_sum[rv_pkg::XLEN-1:1], 1'b0};   // bit 0 cleared
    assign to_res.payload.rd      = ex_q.rd;
    assign to_res.payload.rf_wr   = ex_q.rf_wr;

    assign bypass.ex_wr = ex_valid_q && ex_q.rf_wr;
    assign bypass.ex_rd = ex_q.rd;

endmodule

//--- src/rv_pipe_if.sv
`timescale 1ns/1ps

interface rv_pipe_if #(
    parameter type payload_t = logic
);

    logic     valid;     // payload holds a real instruction
    payload_t payload;
    logic     hold;      // consumer back-pressure, producer keeps its register
    logic     kill;      // flush, consumer loads a bubble

    modport producer (
        output valid, payload,
        input  hold, kill
    );

    modport consumer (
        input  valid, payload,
        output hold, kill
    );

endinterface

//--- src/rv_pkg.sv
package rv_pkg;

    // ---------------------------------------------------------
    // widths and reset
    // ---------------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;   // first fetch address

    // ---------------------------------------------------------
    // encodings
    // ---------------------------------------------------------
    // major opcodes kept by the core, instr[6:2]
    typedef enum logic [4:0] {
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,   // also the branch compare
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // ---------------------------------------------------------
    // stage payloads
    // ---------------------------------------------------------
    // decode -> execute
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [31:0]           instr;
        opcode_e               opcode;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       op_a;    // rs1, forwarded
        logic [XLEN-1:0]       op_b;    // rs2, forwarded
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_wr;
    } dec_payload_t;

    // execute -> result
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       imm;     // U-form for lui/auipc
        logic                  taken;   // branch or jump redirects
        logic [XLEN-1:0]       target;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_wr;
    } exe_payload_t;

endpackage

//--- src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          wr_i,
    input  logic [rv_pkg::XLEN-1:0]       wr_data_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);

    localparam int unsigned NREGS = 2 ** rv_pkg::REG_ADDR_W;

    logic [rv_pkg::XLEN-1:0] regs_q [1:NREGS-1];   // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i && rd_i != '0) begin   // x0 writes dropped
            regs_q[rd_i] <= wr_data_i;
        end
    end

    // combinational read, x0 is hardwired zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- src/rv_result.sv
`timescale 1ns/1ps

module rv_result (
    input  logic                          clk,
    input  logic                          rst_n,
    rv_pipe_if.consumer                   from_exe,
    rv_bypass_if.result                   bypass,
    output logic                          rf_wr_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rf_rd_o,
    output logic [rv_pkg::XLEN-1:0]       rf_data_o,
    output logic                          redirect_o,
    output logic [rv_pkg::XLEN-1:0]       redirect_pc_o,
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    logic                    res_valid_q;
    rv_pkg::exe_payload_t    res_q;
    logic                    wr_en;
    logic [rv_pkg::XLEN-1:0] wr_data;

    assign from_exe.hold = 1'b0;         // write-back never stalls
    assign from_exe.kill = redirect_o;   // drops the three younger ones

    // ---------------------------------------------------------
    // result register
    // ---------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else if (from_exe.kill) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= from_exe.valid;
        end
    end

    always_ff @(posedge clk) begin
        res_q <= from_exe.payload;
    end

    // written value by opcode
    always_comb begin
        case (res_q.opcode)
            rv_pkg::OPC_LUI:   wr_data = res_q.imm;
            rv_pkg::OPC_AUIPC: wr_data = res_q.pc + res_q.imm;
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: wr_data = res_q.pc + 32'd4;   // link
            default:           wr_data = res_q.alu_res;
        endcase
    end

    assign wr_en         = res_valid_q && res_q.rf_wr;
    assign redirect_o    = res_valid_q && res_q.taken;
    assign redirect_pc_o = res_q.target;

    assign rf_wr_o   = wr_en;
    assign rf_rd_o   = res_q.rd;
    assign rf_data_o = wr_data;

    // only writes that change state are reported
    assign wb_valid_o = wr_en && res_q.rd != '0;
    assign wb_rd_o    = res_q.rd;
    assign wb_data_o  = wr_data;

    assign bypass.res_wr   = wr_en;
    assign bypass.res_rd   = res_q.rd;
    assign bypass.res_data = wr_data;

endmodule
